/* build.f */
+incdir+.
pkt_cut_pkg.sv
word_fifo.sv
cut_decode.sv
hash_execute.sv
cut_result.sv
packet_cutter.sv
tb_clkgen.sv
tb_packet_cutter.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the packet cutter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f build.f \
	--top-module tb_packet_cutter \
	--Mdir obj_dir \
	-o sim_packet_cutter
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/sim_packet_cutter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1

/* tb_packet_cutter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet cutter testbench
// random packets against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module tb_packet_cutter;

	typedef pkt_cut_pkg::stream_word_t word_q_t[$];

	localparam int MAX_LEN   = 12;
	localparam int T1_PKTS   = 10;
	localparam int T5_ROUNDS = 8;
	localparam int T5_PKTS   = 5;
	localparam int IN_FLIGHT = (1 << `PC_FIFO_DEPTH_BITS) + 1; // FIFO entries plus output word
	// directed packet words 9, 1+2+3+4+5, 1+3+7 and one stalled packet
	localparam int MAX_WORDS   = T1_PKTS*MAX_LEN + 9 + 15 + 11 + MAX_LEN
		+ T5_ROUNDS*T5_PKTS*MAX_LEN;
	localparam int CYCLE_LIMIT = 200*MAX_WORDS + 1000;

	logic                   axi_aclk;
	logic                   axi_resetn;
	logic [`PC_DATA_W-1:0]  s_axis_tdata;
	logic [`PC_STRB_W-1:0]  s_axis_tstrb;
	logic [`PC_USER_W-1:0]  s_axis_tuser;
	logic                   s_axis_tvalid;
	logic                   s_axis_tready;
	logic                   s_axis_tlast;
	logic [`PC_DATA_W-1:0]  m_axis_tdata;
	logic [`PC_STRB_W-1:0]  m_axis_tstrb;
	logic [`PC_USER_W-1:0]  m_axis_tuser;
	logic                   m_axis_tvalid;
	logic                   m_axis_tready;
	logic                   m_axis_tlast;
	logic                   cut_en;
	logic [`PC_CNT_W-1:0]   cut_words;

	word_q_t                    exp_q; // expected output words in order
	pkt_cut_pkg::stream_word_t  exp_w;
	logic                       random_ready;
	logic                       stall_out;
	int errors       = 0;
	int test_errors  = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles       = 0;
	int in_words     = 0;
	int base_words   = 0;

	tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(4)) clkgen_i (.axi_aclk, .axi_resetn);

	packet_cutter dut_i (
		.axi_aclk, .axi_resetn,
		.s_axis_tdata, .s_axis_tstrb, .s_axis_tuser, .s_axis_tvalid, .s_axis_tready,
		.s_axis_tlast,
		.m_axis_tdata, .m_axis_tstrb, .m_axis_tuser, .m_axis_tvalid, .m_axis_tready,
		.m_axis_tlast,
		.cut_en, .cut_words
	);

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	function automatic word_q_t make_packet(input int len);
		word_q_t                   words;
		pkt_cut_pkg::stream_word_t w;
		logic [31:0]               r;
		for (int i = 0; i < len; i++) begin
			w.data = {$urandom, $urandom};
			r      = $urandom;
			w.strb = r[`PC_STRB_W-1:0];
			w.user = r[31:16];
			w.last = (i == len - 1);
			words.push_back(w);
		end
		return words;
	endfunction

	// reference model keeps cnt words and XORs the rest into one appended word
	function automatic word_q_t expected_packet(input word_q_t words, input logic en,
		input int cnt);
		word_q_t                   res;
		pkt_cut_pkg::stream_word_t d;
		logic [`PC_DATA_W-1:0]     dig;
		int                        n;
		n = words.size();
		if (!en || n <= cnt)
			return words; // short or disabled packets pass untouched
		dig = '0;
		for (int i = 0; i < cnt; i++)
			res.push_back(words[i]);
		for (int i = cnt; i < n; i++) begin
			for (int b = 0; b < `PC_STRB_W; b++)
				if (words[i].strb[b])
					dig[b*8 +: 8] = dig[b*8 +: 8] ^ words[i].data[b*8 +: 8];
		end
		d.data = dig;
		d.strb = '1;
		d.user = words[n-1].user;
		d.last = 1'b1;
		res.push_back(d);
		return res;
	endfunction

	task automatic set_cut(input logic en, input logic [`PC_CNT_W-1:0] words);
		@(negedge axi_aclk);
		cut_en    = en;
		cut_words = words;
	endtask

	task automatic send_packet(input word_q_t words);
		word_q_t exp;
		exp = expected_packet(words, cut_en, int'(cut_words));
		foreach (exp[i])
			exp_q.push_back(exp[i]);
		foreach (words[i]) begin
			@(negedge axi_aclk);
			s_axis_tvalid = 1'b1;
			s_axis_tdata  = words[i].data;
			s_axis_tstrb  = words[i].strb;
			s_axis_tuser  = words[i].user;
			s_axis_tlast  = words[i].last;
			while (!s_axis_tready) // ready only moves on rising edges
				@(negedge axi_aclk);
		end
		@(negedge axi_aclk);
		s_axis_tvalid = 1'b0;
	endtask

	task automatic drain_output();
		while (exp_q.size() != 0)
			@(negedge axi_aclk);
		repeat (5) @(negedge axi_aclk); // room for any stray extra word
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// output sink
	initial begin
		m_axis_tready = 1'b0;
		forever begin
			@(negedge axi_aclk);
			if (stall_out)
				m_axis_tready = 1'b0;
			else if (random_ready)
				m_axis_tready = ($urandom_range(3) != 0);
			else
				m_axis_tready = 1'b1;
		end
	end

	// compare on every master handshake
	always @(posedge axi_aclk) begin
		if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
			if (exp_q.size() == 0) begin
				$display("unexpected output word 0x%h when no word was due", m_axis_tdata);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				check_value("m_axis_tdata", m_axis_tdata, exp_w.data);
				check_value("m_axis_tstrb", 64'(m_axis_tstrb), 64'(exp_w.strb));
				check_value("m_axis_tuser", 64'(m_axis_tuser), 64'(exp_w.user));
				check_value("m_axis_tlast", 64'(m_axis_tlast), 64'(exp_w.last));
			end
		end
	end

	// words taken on the slave side
	always @(posedge axi_aclk) begin
		if (axi_resetn && s_axis_tvalid && s_axis_tready)
			in_words++;
	end

	always @(posedge axi_aclk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, output words still missing: %0d",
				cycles, exp_q.size());
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h77c7577f));
		random_ready  = 1'b0;
		stall_out     = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tstrb  = '0;
		s_axis_tuser  = '0;
		s_axis_tlast  = 1'b0;
		cut_en        = 1'b0;
		cut_words     = '0;

		wait (axi_resetn === 1'b1);
		@(negedge axi_aclk);
		check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
		report_test("reset");

		set_cut(1'b0, 16'd3);
		for (int p = 0; p < T1_PKTS; p++)
			send_packet(make_packet($urandom_range(MAX_LEN, 1)));
		drain_output();
		report_test("cut disabled");

		set_cut(1'b1, 16'd3);
		send_packet(make_packet(9));
		drain_output();
		report_test("keep 3 of 9");

		set_cut(1'b1, 16'd5);
		for (int len = 1; len <= 5; len++)
			send_packet(make_packet(len)); // up to exactly cut_words
		drain_output();
		report_test("short packets");

		set_cut(1'b1, 16'd0);
		send_packet(make_packet(1));
		send_packet(make_packet(3));
		send_packet(make_packet(7));
		drain_output();
		report_test("digest only");

		// output held off so the FIFO fills and pushes back
		set_cut(1'b0, 16'd3);
		base_words = in_words;
		@(posedge axi_aclk);
		stall_out = 1'b1;
		fork
			send_packet(make_packet(MAX_LEN));
			begin
				repeat (2*MAX_LEN) @(negedge axi_aclk); // well past the fill
				if (in_words - base_words > IN_FLIGHT) begin
					$display("%0d words taken while the output was stalled, only %0d fit",
						in_words - base_words, IN_FLIGHT);
					errors++;
				end
				check_value("s_axis_tready", 64'(s_axis_tready), 64'd0);
				check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd1);
				check_value("m_axis_tdata", m_axis_tdata, exp_q[0].data); // first word held
				@(posedge axi_aclk);
				stall_out = 1'b0;
			end
		join
		drain_output();
		report_test("output stall");

		random_ready = 1'b1;
		for (int r = 0; r < T5_ROUNDS; r++) begin
			// cut_en and cut_words change only while the DUT is idle
			set_cut(($urandom_range(3) != 0), `PC_CNT_W'($urandom_range(MAX_LEN, 0)));
			for (int p = 0; p < T5_PKTS; p++)
				send_packet(make_packet($urandom_range(MAX_LEN, 1)));
			drain_output();
		end
		random_ready = 1'b0;
		report_test("random back-pressure");

		$display("tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic axi_aclk,
	output logic axi_resetn
);

	initial begin
		axi_aclk = 1'b0;
		forever #(PERIOD_NS / 2) axi_aclk = ~axi_aclk;
	end

	// reset low for the first rising edges, released mid-cycle
	initial begin
		axi_resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge axi_aclk);
		@(negedge axi_aclk);
		axi_resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* packet_cutter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream packet cutter top
// keeps the first words, folds the rest into a digest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module packet_cutter (
	input  wire logic                   axi_aclk,
	input  wire logic                   axi_resetn,
	input  wire logic [`PC_DATA_W-1:0]  s_axis_tdata,
	input  wire logic [`PC_STRB_W-1:0]  s_axis_tstrb,
	input  wire logic [`PC_USER_W-1:0]  s_axis_tuser,
	input  wire logic                   s_axis_tvalid,
	output logic                        s_axis_tready,
	input  wire logic                   s_axis_tlast,
	output logic      [`PC_DATA_W-1:0]  m_axis_tdata,
	output logic      [`PC_STRB_W-1:0]  m_axis_tstrb,
	output logic      [`PC_USER_W-1:0]  m_axis_tuser,
	output logic                        m_axis_tvalid,
	input  wire logic                   m_axis_tready,
	output logic                        m_axis_tlast,
	input  wire logic                   cut_en,
	input  wire logic [`PC_CNT_W-1:0]   cut_words
);

	pkt_cut_pkg::stream_word_t  s_word;
	pkt_cut_pkg::stream_word_t  head;
	pkt_cut_pkg::stream_word_t  out_word;
	pkt_cut_pkg::decoded_word_t issue;
	logic                       head_valid, nearly_full, pop;
	logic                       issue_valid, accept;
	logic [`PC_DATA_W-1:0]      digest;

	assign s_word = '{data: s_axis_tdata, strb: s_axis_tstrb,
		user: s_axis_tuser, last: s_axis_tlast};
	assign s_axis_tready = ~nearly_full;

	word_fifo #(
		.WIDTH      ($bits(pkt_cut_pkg::stream_word_t)),
		.DEPTH_BITS (`PC_FIFO_DEPTH_BITS)
	) in_fifo_i (
		.axi_aclk, .axi_resetn,
		.din         (s_word),
		.wr_en       (s_axis_tvalid & ~nearly_full),
		.pop, .head, .head_valid, .nearly_full
	);

	cut_decode decode_i (.axi_aclk, .axi_resetn, .head, .head_valid, .accept,
		.cut_en, .cut_words, .pop, .issue, .issue_valid);

	hash_execute execute_i (.axi_aclk, .axi_resetn, .issue, .issue_valid, .digest);

	cut_result result_i (.axi_aclk, .axi_resetn, .issue, .issue_valid, .digest,
		.m_axis_tready, .out_word, .out_valid(m_axis_tvalid), .accept);

	assign m_axis_tdata = out_word.data;
	assign m_axis_tstrb = out_word.strb;
	assign m_axis_tuser = out_word.user;
	assign m_axis_tlast = out_word.last;

endmodule

`default_nettype wire

/* cut_result.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output register stage
// drives the master stream, appends the digest word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module cut_result (
	input  wire logic                        axi_aclk,
	input  wire logic                        axi_resetn,
	input  wire pkt_cut_pkg::decoded_word_t  issue,
	input  wire logic                        issue_valid,
	input  wire logic [`PC_DATA_W-1:0]       digest,
	input  wire logic                        m_axis_tready,
	output pkt_cut_pkg::stream_word_t        out_word,
	output logic                             out_valid,
	output logic                             accept
);

	pkt_cut_pkg::stream_word_t digest_word;
	logic                      load;

	// register empty or draining this cycle
	assign accept = ~out_valid | m_axis_tready;

	// fold words only feed the accumulator
	assign load = issue_valid && (issue.kind != pkt_cut_pkg::kind_fold);

	always_comb begin
		digest_word.data = digest;
		digest_word.strb = {`PC_STRB_W{1'b1}};
		digest_word.user = issue.word.user; // tuser of the final input word
		digest_word.last = 1'b1;
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= load;
	end

	// payload, no reset
	always_ff @(posedge axi_aclk) begin
		if (accept && load) begin
			if (issue.kind == pkt_cut_pkg::kind_fold_end)
				out_word <= digest_word;
			else
				out_word <= issue.word;
		end
	end

endmodule

`default_nettype wire

/* hash_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// digest accumulator
// XOR of the strobe-masked folded words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module hash_execute (
	input  wire logic                        axi_aclk,
	input  wire logic                        axi_resetn,
	input  wire pkt_cut_pkg::decoded_word_t  issue,
	input  wire logic                        issue_valid,
	output logic [`PC_DATA_W-1:0]            digest
);

	logic [`PC_DATA_W-1:0] acc;
	logic [`PC_DATA_W-1:0] masked;

	// zero bytes whose strobe is low
	always_comb begin
		for (int i = 0; i < `PC_STRB_W; i++)
			masked[i*8 +: 8] = issue.word.data[i*8 +: 8] & {8{issue.word.strb[i]}};
	end

	assign digest = acc ^ masked;

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			acc <= '0;
		end else if (issue_valid) begin
			case (issue.kind)
				pkt_cut_pkg::kind_fold:     acc <= digest;
				pkt_cut_pkg::kind_fold_end: acc <= '0; // ready for next packet
				default:                    acc <= acc;
			endcase
		end
	end

endmodule

`default_nettype wire

/* cut_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cut decode
// tags each FIFO word forward, fold or fold-end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module cut_decode (
	input  wire logic                       axi_aclk,
	input  wire logic                       axi_resetn,
	input  wire pkt_cut_pkg::stream_word_t  head,
	input  wire logic                       head_valid,
	input  wire logic                       accept,
	input  wire logic                       cut_en,
	input  wire logic [`PC_CNT_W-1:0]       cut_words,
	output logic                            pop,
	output pkt_cut_pkg::decoded_word_t      issue,
	output logic                            issue_valid
);

	pkt_cut_pkg::cut_state_e state;
	logic [`PC_CNT_W-1:0]    remaining; // words still to forward
	logic [`PC_CNT_W-1:0]    cur_cnt;
	logic                    fire;
	logic                    fold_now;

	assign fire = head_valid & accept;
	assign pop  = fire;
	assign issue_valid = fire;

	// cut settings are sampled only on the first word
	always_comb begin
		if (state == pkt_cut_pkg::st_first)
			cur_cnt = cut_en ? cut_words : {`PC_CNT_W{1'b1}};
		else
			cur_cnt = remaining;
	end

	assign fold_now = (state == pkt_cut_pkg::st_fold) || (cur_cnt == '0);

	always_comb begin
		issue.word = head;
		if (!fold_now)
			issue.kind = pkt_cut_pkg::kind_forward; // tlast left untouched
		else if (head.last)
			issue.kind = pkt_cut_pkg::kind_fold_end;
		else
			issue.kind = pkt_cut_pkg::kind_fold;
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			state     <= pkt_cut_pkg::st_first;
			remaining <= '0;
		end else if (fire) begin
			if (!fold_now)
				remaining <= cur_cnt - 1'b1;

			if (head.last)
				state <= pkt_cut_pkg::st_first; // any tlast ends the packet
			else if (fold_now || cur_cnt == `PC_CNT_W'(1))
				state <= pkt_cut_pkg::st_fold; // keep budget used up
			else
				state <= pkt_cut_pkg::st_keep;
		end
	end

endmodule

`default_nettype wire

/* word_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through input FIFO
// head shown without a read, nearly-full flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cut_defs.svh"

module word_fifo #(
	parameter int WIDTH      = 89,
	parameter int DEPTH_BITS = 3
) (
	input  wire logic             axi_aclk,
	input  wire logic             axi_resetn,
	input  wire logic [WIDTH-1:0] din,
	input  wire logic             wr_en,
	input  wire logic             pop,
	output logic      [WIDTH-1:0] head,
	output logic                  head_valid,
	output logic                  nearly_full
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count; // one extra bit to tell full from empty
	logic [DEPTH_BITS:0]   free_cnt;
	logic                  do_pop;

	assign do_pop     = pop & head_valid;
	assign head       = mem[rd_ptr]; // fall-through, no read latency
	assign head_valid = (count != '0);
	assign free_cnt   = (DEPTH_BITS+1)'(DEPTH) - count;
	assign nearly_full = (free_cnt <= (DEPTH_BITS+1)'(`PC_FIFO_SLACK));

	always_ff @(posedge axi_aclk) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* pkt_cut_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet cutter types
// stream word, decoded word, opcodes and states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pkt_cut_defs.svh"

package pkt_cut_pkg;

	typedef struct packed {
		logic [`PC_DATA_W-1:0] data;
		logic [`PC_STRB_W-1:0] strb;
		logic [`PC_USER_W-1:0] user;
		logic                  last;
	} stream_word_t;

	// what to do with a word leaving the FIFO
	typedef enum logic [1:0] {
		kind_forward  = 2'd0,
		kind_fold     = 2'd1,
		kind_fold_end = 2'd2 // last folded word, digest goes out
	} word_kind_e;

	typedef struct packed {
		stream_word_t word;
		word_kind_e   kind;
	} decoded_word_t;

	typedef enum logic [1:0] {st_first, st_keep, st_fold} cut_state_e;

endpackage

`default_nettype wire

/* pkt_cut_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet cutter widths and limits
// stream sizes and input FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PKT_CUT_DEFS_SVH
`define PKT_CUT_DEFS_SVH

// stream widths
`define PC_DATA_W 64
`define PC_STRB_W (`PC_DATA_W / 8)
`define PC_USER_W 16

// width of the kept-word count
`define PC_CNT_W 16

// input FIFO: 8 entries
`define PC_FIFO_DEPTH_BITS 3
// free entries left when nearly_full rises
`define PC_FIFO_SLACK 2

`endif
